// File: src.f
+incdir+hw
hw/gat_pkg.sv
hw/gat_cmd_decoder.sv
hw/gat_stage_engine.sv
hw/gat_debug_monitor.sv
hw/gat_top.sv
tb/tb_gat_top.sv

// File: Bender.yml
package:
  name: gat_stage_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/gat_pkg.sv
      - hw/gat_cmd_decoder.sv
      - hw/gat_stage_engine.sv
      - hw/gat_debug_monitor.sv
      - hw/gat_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_gat_top.sv

// File: tb/tb_gat_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "gat_params.svh"

module tb_gat_top;

  localparam int NUM_ENTRIES = 18;
  localparam int CYCLE_LIMIT = NUM_ENTRIES * 20 + 50;

  typedef struct packed {
    gat_pkg::gat_op_e         op;
    logic [`GAT_LEN_W-1:0]    len;
    logic [`GAT_ARG_W-1:0]    arg;
    logic [`GAT_OPND_W-1:0]   base;
    logic                     busy_strobe;
    logic [`GAT_RES_W-1:0]    exp_res;
    logic [`GAT_RES_W-1:0]    exp_flags;
    logic [`GAT_RES_W-1:0]    exp_count;
    logic [`GAT_RES_W-1:0]    exp_cap;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_strobe_i;
  gat_pkg::gat_op_e       cmd_op_i;
  logic [`GAT_LEN_W-1:0]  cmd_len_i;
  logic [`GAT_ARG_W-1:0]  cmd_arg_i;
  logic [`GAT_OPND_W-1:0] operand_i;
  logic                   busy_o;
  logic                   operand_req_o;
  logic [`GAT_RES_W-1:0]  result_o;
  gat_pkg::gat_op_e       result_op_o;
  logic                   result_valid_o;
  logic [3:0]             phase_vld_o;
  logic [3:0]             phase_rdy_o;
  logic [`GAT_RES_W-1:0]  dbg_flags_o;
  logic [`GAT_RES_W-1:0]  dbg_count_o;
  logic [`GAT_RES_W-1:0]  dbg_capture_o;

  entry_t tbl [NUM_ENTRIES];
  int     cyc;
  integer seed;

  gat_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_strobe_i   (cmd_strobe_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_len_i      (cmd_len_i),
    .cmd_arg_i      (cmd_arg_i),
    .operand_i      (operand_i),
    .busy_o         (busy_o),
    .operand_req_o  (operand_req_o),
    .result_o       (result_o),
    .result_op_o    (result_op_o),
    .result_valid_o (result_valid_o),
    .phase_vld_o    (phase_vld_o),
    .phase_rdy_o    (phase_rdy_o),
    .dbg_flags_o    (dbg_flags_o),
    .dbg_count_o    (dbg_count_o),
    .dbg_capture_o  (dbg_capture_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk) begin
    if (cyc >= CYCLE_LIMIT) begin
      stop_on_fail($sformatf("timeout: no progress after %0d cycles", CYCLE_LIMIT));
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic bit is_phase_cmd(input gat_pkg::gat_op_e op,
                                      input logic [`GAT_LEN_W-1:0] len);
    return (len != 0) && (op inside {gat_pkg::SPMM, gat_pkg::DMVM,
                                     gat_pkg::SM, gat_pkg::AGGR});
  endfunction

  function automatic logic [`GAT_RES_W-1:0] ref_result(input gat_pkg::gat_op_e op,
      input logic [`GAT_LEN_W-1:0] len, input logic [`GAT_ARG_W-1:0] arg,
      input logic [`GAT_OPND_W-1:0] base);
    logic [`GAT_RES_W-1:0]  acc;
    logic [`GAT_OPND_W-1:0] opnd;
    int                     k;
    acc = '0;
    for (k = 0; k < len; k++) begin
      opnd = base + `GAT_OPND_W'(k);
      case (op)
        gat_pkg::SPMM, gat_pkg::AGGR: acc = acc + 32'(opnd);
        gat_pkg::DMVM: acc = acc + 32'(opnd) * 32'(arg);
        gat_pkg::SM:   acc = (32'(opnd) > acc) ? 32'(opnd) : acc;
        default:       acc = acc;
      endcase
    end
    if (op == gat_pkg::AGGR) begin
      acc = acc >> arg;
    end
    return acc;
  endfunction

  // valid and ready flag pair of one phase.
  function automatic logic [8:0] phase_flags(input gat_pkg::gat_op_e op);
    case (op)
      gat_pkg::SPMM: return 9'h0c0;
      gat_pkg::DMVM: return 9'h030;
      gat_pkg::SM:   return 9'h00c;
      gat_pkg::AGGR: return 9'h003;
      default:       return 9'h000;
    endcase
  endfunction

  // strobe bit of one phase, spmm lowest.
  function automatic logic [3:0] phase_bit(input gat_pkg::gat_op_e op);
    case (op)
      gat_pkg::SPMM: return 4'b0001;
      gat_pkg::DMVM: return 4'b0010;
      gat_pkg::SM:   return 4'b0100;
      gat_pkg::AGGR: return 4'b1000;
      default:       return 4'b0000;
    endcase
  endfunction

  task automatic set_entry(input int i, input gat_pkg::gat_op_e op, input int len,
                           input int arg, input logic [`GAT_OPND_W-1:0] base,
                           input bit busy_strobe);
    tbl[i]             = '0;
    tbl[i].op          = op;
    tbl[i].len         = `GAT_LEN_W'(len);
    tbl[i].arg         = `GAT_ARG_W'(arg);
    tbl[i].base        = base;
    tbl[i].busy_strobe = busy_strobe;
  endtask

  task automatic build_table();
    logic [8:0]            m_flags;
    logic [`GAT_RES_W-1:0] m_count;
    logic [`GAT_RES_W-1:0] m_cap;
    int                    i;
    set_entry(0,  gat_pkg::SPMM,        1,  0,  16'h0005, 1'b0);
    set_entry(1,  gat_pkg::SPMM,        15, 0,  16'($random(seed)), 1'b0);
    set_entry(2,  gat_pkg::DMVM,        1,  3,  16'h0101, 1'b0);
    set_entry(3,  gat_pkg::DMVM,        15, 15, 16'($random(seed)), 1'b0);
    set_entry(4,  gat_pkg::SM,          1,  0,  16'h00a0, 1'b0);
    set_entry(5,  gat_pkg::SM,          15, 0,  16'($random(seed)), 1'b0);
    set_entry(6,  gat_pkg::AGGR,        1,  0,  16'h1234, 1'b0);
    set_entry(7,  gat_pkg::AGGR,        15, 2,  16'($random(seed)), 1'b0);
    set_entry(8,  gat_pkg::AGGR,        7,  5,  16'hfff0, 1'b0);
    set_entry(9,  gat_pkg::CLEAR_DEBUG, 1,  0,  16'h0000, 1'b0);
    set_entry(10, gat_pkg::SPMM,        4,  0,  16'($random(seed)), 1'b0);
    set_entry(11, gat_pkg::SPMM,        2,  0,  16'h0777, 1'b0);
    set_entry(12, gat_pkg::NOP,         4,  0,  16'h0000, 1'b0);
    set_entry(13, gat_pkg::SM,          0,  0,  16'h0000, 1'b0);
    set_entry(14, gat_pkg::SM,          6,  0,  16'($random(seed)), 1'b1);
    set_entry(15, gat_pkg::DMVM,        5,  7,  16'h2000, 1'b0);
    set_entry(16, gat_pkg::CLEAR_DEBUG, 1,  0,  16'h0000, 1'b0);
    set_entry(17, gat_pkg::SM,          3,  0,  16'h8000, 1'b0);
    m_flags = '0;
    m_count = '0;
    m_cap   = '0;
    for (i = 0; i < NUM_ENTRIES; i++) begin
      if (is_phase_cmd(tbl[i].op, tbl[i].len)) begin
        tbl[i].exp_res = ref_result(tbl[i].op, tbl[i].len, tbl[i].arg, tbl[i].base);
        m_flags = m_flags | phase_flags(tbl[i].op);
        if (tbl[i].op == gat_pkg::SM) begin
          m_count = m_count + 32'(tbl[i].len);
        end
        if (tbl[i].op == gat_pkg::SPMM && tbl[i].len > `GAT_DBG_WATCH_BEAT) begin
          m_cap = 32'(16'(tbl[i].base + `GAT_DBG_WATCH_BEAT));
        end
      end else if (tbl[i].op == gat_pkg::CLEAR_DEBUG && tbl[i].len != 0) begin
        m_flags = '0;
        m_count = '0;
        m_cap   = '0;
      end else begin
        m_flags[8] = 1'b1;
      end
      tbl[i].exp_flags = 32'(m_flags);
      tbl[i].exp_count = m_count;
      tbl[i].exp_cap   = m_cap;
    end
  endtask

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic stop_on_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_result(input gat_pkg::gat_op_e exp_op,
                              input logic [`GAT_RES_W-1:0] exp_res);
    if (result_op_o !== exp_op) begin
      stop_on_fail($sformatf("error: result_op_o = %h, expected %h", result_op_o, exp_op));
    end
    if (result_o !== exp_res) begin
      stop_on_fail($sformatf("error: result_o = %h, expected %h", result_o, exp_res));
    end
  endtask

  task automatic check_phase(input logic [3:0] exp_vld, input logic [3:0] exp_rdy);
    if (phase_vld_o !== exp_vld) begin
      stop_on_fail($sformatf("error: phase_vld_o = %h, expected %h", phase_vld_o, exp_vld));
    end
    if (phase_rdy_o !== exp_rdy) begin
      stop_on_fail($sformatf("error: phase_rdy_o = %h, expected %h", phase_rdy_o, exp_rdy));
    end
  endtask

  task automatic check_debug(input logic [`GAT_RES_W-1:0] exp_flags,
                             input logic [`GAT_RES_W-1:0] exp_count,
                             input logic [`GAT_RES_W-1:0] exp_cap);
    if (dbg_flags_o !== exp_flags) begin
      stop_on_fail($sformatf("error: dbg_flags_o = %h, expected %h", dbg_flags_o, exp_flags));
    end
    if (dbg_count_o !== exp_count) begin
      stop_on_fail($sformatf("error: dbg_count_o = %h, expected %h", dbg_count_o, exp_count));
    end
    if (dbg_capture_o !== exp_cap) begin
      stop_on_fail($sformatf("error: dbg_capture_o = %h, expected %h",
                             dbg_capture_o, exp_cap));
    end
  endtask

  task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
      stop_on_fail($sformatf("error: result_valid_o latency = %h, expected %h",
                             got, expected));
    end
  endtask

  // ----------------------------------------
  // command sequencing
  // ----------------------------------------
  task automatic run_entry(input int i);
    entry_t e;
    int     beat;
    int     start_cyc;
    int     k;
    bit     in_run;
    e = tbl[i];
    @(posedge clk);
    #2;
    if (busy_o) begin
      stop_on_fail($sformatf("busy_o was still high before command %0d", i));
    end
    cmd_strobe_i = 1'b1;
    cmd_op_i     = e.op;
    cmd_len_i    = e.len;
    cmd_arg_i    = e.arg;
    @(posedge clk);
    #2;
    start_cyc    = cyc;
    cmd_strobe_i = 1'b0;
    if (is_phase_cmd(e.op, e.len)) begin
      beat = 0;
      while (!result_valid_o) begin
        in_run = (cyc - start_cyc >= 1) && (cyc - start_cyc <= int'(e.len));
        check_phase(in_run ? phase_bit(e.op) : 4'b0000, 4'b0000);
        if (operand_req_o) begin
          operand_i = e.base + `GAT_OPND_W'(beat);
          beat++;
        end else if (e.busy_strobe && beat == int'(e.len)) begin
          // strobe in the cycle before the result must be dropped.
          if (!busy_o) begin
            stop_on_fail("busy_o was low just before the result");
          end
          cmd_strobe_i = 1'b1;
          cmd_op_i     = gat_pkg::SPMM;
          cmd_len_i    = `GAT_LEN_W'(3);
        end
        @(posedge clk);
        #2;
        cmd_strobe_i = 1'b0;
      end
      check_latency(cyc - start_cyc, int'(e.len) + 2);
      if (beat != e.len) begin
        stop_on_fail($sformatf("command %0d took %0d operands instead of %0d",
                               i, beat, e.len));
      end
      check_phase(4'b0000, phase_bit(e.op));
      check_result(e.op, e.exp_res);
      // ready flag lands one cycle after the result.
      @(posedge clk);
      #2;
    end else begin
      for (k = 0; k < 3; k++) begin
        if (result_valid_o || operand_req_o) begin
          stop_on_fail($sformatf("command %0d without a phase started the engine", i));
        end
        check_phase(4'b0000, 4'b0000);
        @(posedge clk);
        #2;
      end
    end
    check_debug(e.exp_flags, e.exp_count, e.exp_cap);
  endtask

  initial begin
    int i;
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_strobe_i = 1'b0;
    cmd_op_i     = gat_pkg::NOP;
    cmd_len_i    = '0;
    cmd_arg_i    = '0;
    operand_i    = '0;
    cyc          = 0;
    seed         = 80;
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_debug('0, '0, '0);
    for (i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(i);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/gat_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "gat_params.svh"

module gat_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   cmd_strobe_i,
  input  wire gat_pkg::gat_op_e       cmd_op_i,
  input  wire logic [`GAT_LEN_W-1:0]  cmd_len_i,
  input  wire logic [`GAT_ARG_W-1:0]  cmd_arg_i,
  input  wire logic [`GAT_OPND_W-1:0] operand_i,
  output logic                        busy_o,
  output logic                        operand_req_o,
  output logic [`GAT_RES_W-1:0]       result_o,
  output gat_pkg::gat_op_e            result_op_o,
  output logic                        result_valid_o,
  output logic [3:0]                  phase_vld_o,
  output logic [3:0]                  phase_rdy_o,
  output logic [`GAT_RES_W-1:0]       dbg_flags_o,
  output logic [`GAT_RES_W-1:0]       dbg_count_o,
  output logic [`GAT_RES_W-1:0]       dbg_capture_o
);

  logic                  start;
  gat_pkg::gat_op_e      start_op;
  logic [`GAT_LEN_W-1:0] start_len;
  logic [`GAT_ARG_W-1:0] start_arg;
  logic                  dbg_clear;
  logic                  bad_cmd;
  logic                  pending;
  logic                  eng_busy;
  logic [`GAT_LEN_W-1:0] beat_idx;

  // decoder holds busy until the engine picks up start.
  assign busy_o = eng_busy || pending;

  gat_cmd_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_strobe_i (cmd_strobe_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_len_i    (cmd_len_i),
    .cmd_arg_i    (cmd_arg_i),
    .busy_i       (eng_busy),
    .start_o      (start),
    .start_op_o   (start_op),
    .start_len_o  (start_len),
    .start_arg_o  (start_arg),
    .dbg_clear_o  (dbg_clear),
    .bad_cmd_o    (bad_cmd),
    .pending_o    (pending)
  );

  gat_stage_engine u_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start),
    .start_op_i     (start_op),
    .start_len_i    (start_len),
    .start_arg_i    (start_arg),
    .operand_i      (operand_i),
    .busy_o         (eng_busy),
    .operand_req_o  (operand_req_o),
    .beat_idx_o     (beat_idx),
    .result_o       (result_o),
    .result_op_o    (result_op_o),
    .result_valid_o (result_valid_o),
    .phase_vld_o    (phase_vld_o),
    .phase_rdy_o    (phase_rdy_o)
  );

  gat_debug_monitor u_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .dbg_clear_i   (dbg_clear),
    .bad_cmd_i     (bad_cmd),
    .phase_vld_i   (phase_vld_o),
    .phase_rdy_i   (phase_rdy_o),
    .operand_req_i (operand_req_o),
    .beat_idx_i    (beat_idx),
    .operand_i     (operand_i),
    .dbg_flags_o   (dbg_flags_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

endmodule

`default_nettype wire

// File: hw/gat_debug_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "gat_params.svh"

module gat_debug_monitor (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   dbg_clear_i,
  input  wire logic                   bad_cmd_i,
  input  wire logic [3:0]             phase_vld_i,
  input  wire logic [3:0]             phase_rdy_i,
  input  wire logic                   operand_req_i,
  input  wire logic [`GAT_LEN_W-1:0]  beat_idx_i,
  input  wire logic [`GAT_OPND_W-1:0] operand_i,
  output logic [`GAT_RES_W-1:0]       dbg_flags_o,
  output logic [`GAT_RES_W-1:0]       dbg_count_o,
  output logic [`GAT_RES_W-1:0]       dbg_capture_o
);

  logic [8:0] flags_q;
  logic [8:0] flags_set;
  logic       sm_beat;
  logic       watch_hit;

  // ----------------------------------------
  // sticky flags
  // ----------------------------------------

  // spmm in the top bits, bad command above them.
  assign flags_set = {
    bad_cmd_i,
    phase_vld_i[gat_pkg::PH_SPMM], phase_rdy_i[gat_pkg::PH_SPMM],
    phase_vld_i[gat_pkg::PH_DMVM], phase_rdy_i[gat_pkg::PH_DMVM],
    phase_vld_i[gat_pkg::PH_SM],   phase_rdy_i[gat_pkg::PH_SM],
    phase_vld_i[gat_pkg::PH_AGGR], phase_rdy_i[gat_pkg::PH_AGGR]
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (dbg_clear_i) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_q | flags_set;
    end
  end

  assign dbg_flags_o = {{(`GAT_RES_W-9){1'b0}}, flags_q};

  // ----------------------------------------
  // softmax beats and spmm capture
  // ----------------------------------------
  assign sm_beat   = operand_req_i && phase_vld_i[gat_pkg::PH_SM];
  assign watch_hit = operand_req_i && phase_vld_i[gat_pkg::PH_SPMM] &&
                     (beat_idx_i == `GAT_LEN_W'(`GAT_DBG_WATCH_BEAT));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_count_o   <= '0;
      dbg_capture_o <= '0;
    end else if (dbg_clear_i) begin
      dbg_count_o   <= '0;
      dbg_capture_o <= '0;
    end else begin
      if (sm_beat) begin
        dbg_count_o <= dbg_count_o + 1'b1;
      end
      // short spmm commands never reach the watch beat.
      if (watch_hit) begin
        dbg_capture_o <= {{(`GAT_RES_W-`GAT_OPND_W){1'b0}}, operand_i};
      end
    end
  end

  a_flags_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !dbg_clear_i |=> ((flags_q & $past(flags_q)) == $past(flags_q)));

endmodule

`default_nettype wire

// File: hw/gat_stage_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "gat_params.svh"

module gat_stage_engine (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   start_i,
  input  wire gat_pkg::gat_op_e       start_op_i,
  input  wire logic [`GAT_LEN_W-1:0]  start_len_i,
  input  wire logic [`GAT_ARG_W-1:0]  start_arg_i,
  input  wire logic [`GAT_OPND_W-1:0] operand_i,
  output logic                        busy_o,
  output logic                        operand_req_o,
  output logic [`GAT_LEN_W-1:0]       beat_idx_o,
  output logic [`GAT_RES_W-1:0]       result_o,
  output gat_pkg::gat_op_e            result_op_o,
  output logic                        result_valid_o,
  output logic [3:0]                  phase_vld_o,
  output logic [3:0]                  phase_rdy_o
);

  gat_pkg::eng_state_e         state_q;
  gat_pkg::gat_op_e            op_q;
  logic [`GAT_LEN_W-1:0]       len_q;
  logic [`GAT_LEN_W-1:0]       cnt_q;
  logic [`GAT_LEN_W-1:0]       cnt_inc;
  logic [`GAT_ARG_W-1:0]       arg_q;
  logic [`GAT_RES_W-1:0]       acc_q;
  logic [`GAT_RES_W-1:0]       acc_nxt;
  logic [`GAT_RES_W-1:0]       opnd_ext;
  logic [`GAT_RES_W-1:0]       res_nxt;
  logic                        last_beat;
  logic [3:0]                  op_bit;

  function automatic logic [3:0] phase_onehot(input gat_pkg::gat_op_e op);
    logic [3:0] oh;
    oh = '0;
    case (op)
      gat_pkg::SPMM: oh[gat_pkg::PH_SPMM] = 1'b1;
      gat_pkg::DMVM: oh[gat_pkg::PH_DMVM] = 1'b1;
      gat_pkg::SM:   oh[gat_pkg::PH_SM]   = 1'b1;
      gat_pkg::AGGR: oh[gat_pkg::PH_AGGR] = 1'b1;
      default:       oh = '0;
    endcase
    return oh;
  endfunction

  assign op_bit    = phase_onehot(op_q);
  assign cnt_inc   = cnt_q + 1'b1;
  assign last_beat = (cnt_inc == len_q);
  assign opnd_ext  = {{(`GAT_RES_W-`GAT_OPND_W){1'b0}}, operand_i};

  // ----------------------------------------
  // per-beat reduction
  // ----------------------------------------
  always_comb begin
    case (op_q)
      gat_pkg::SPMM,
      gat_pkg::AGGR: acc_nxt = acc_q + opnd_ext;
      // weight folded in on every beat.
      gat_pkg::DMVM: acc_nxt = acc_q + opnd_ext * {{(`GAT_RES_W-`GAT_ARG_W){1'b0}}, arg_q};
      gat_pkg::SM:   acc_nxt = (opnd_ext > acc_q) ? opnd_ext : acc_q;
      default:       acc_nxt = acc_q;
    endcase
  end

  assign res_nxt = (op_q == gat_pkg::AGGR) ? (acc_q >> arg_q) : acc_q;

  assign operand_req_o = (state_q == gat_pkg::RUN);
  assign phase_vld_o   = operand_req_o ? op_bit : '0;
  assign beat_idx_o    = cnt_q;
  // result cycle counts as busy too.
  assign busy_o        = (state_q != gat_pkg::IDLE) || result_valid_o;

  // ----------------------------------------
  // sequencing
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= gat_pkg::IDLE;
      cnt_q          <= '0;
      result_valid_o <= 1'b0;
      phase_rdy_o    <= '0;
    end else begin
      result_valid_o <= 1'b0;
      phase_rdy_o    <= '0;
      case (state_q)
        gat_pkg::IDLE: begin
          cnt_q <= '0;
          if (start_i) begin
            state_q <= gat_pkg::RUN;
          end
        end
        gat_pkg::RUN: begin
          cnt_q <= cnt_inc;
          if (last_beat) begin
            state_q <= gat_pkg::DONE;
          end
        end
        gat_pkg::DONE: begin
          state_q        <= gat_pkg::IDLE;
          result_valid_o <= 1'b1;
          phase_rdy_o    <= op_bit;
        end
        default: state_q <= gat_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && (state_q == gat_pkg::IDLE)) begin
      op_q  <= start_op_i;
      len_q <= start_len_i;
      arg_q <= start_arg_i;
      acc_q <= '0;
    end else if (operand_req_o) begin
      acc_q <= acc_nxt;
    end
    if (state_q == gat_pkg::DONE) begin
      result_o    <= res_nxt;
      result_op_o <= op_q;
    end
  end

  a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == gat_pkg::IDLE));

  a_one_phase: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(phase_vld_o));

endmodule

`default_nettype wire

// File: hw/gat_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "gat_params.svh"

module gat_cmd_decoder (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  cmd_strobe_i,
  input  wire gat_pkg::gat_op_e      cmd_op_i,
  input  wire logic [`GAT_LEN_W-1:0] cmd_len_i,
  input  wire logic [`GAT_ARG_W-1:0] cmd_arg_i,
  input  wire logic                  busy_i,
  output logic                       start_o,
  output gat_pkg::gat_op_e           start_op_o,
  output logic [`GAT_LEN_W-1:0]      start_len_o,
  output logic [`GAT_ARG_W-1:0]      start_arg_o,
  output logic                       dbg_clear_o,
  output logic                       bad_cmd_o,
  output logic                       pending_o
);

  logic accept;
  logic len_ok;
  logic is_phase;
  logic is_clear;

  // strobes while busy are dropped.
  assign accept = cmd_strobe_i && !busy_i && !pending_o;
  assign len_ok = (cmd_len_i != '0);

  assign is_phase = len_ok && (cmd_op_i inside {gat_pkg::SPMM, gat_pkg::DMVM,
                                                gat_pkg::SM, gat_pkg::AGGR});
  assign is_clear = len_ok && (cmd_op_i == gat_pkg::CLEAR_DEBUG);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_o   <= 1'b0;
      start_o     <= 1'b0;
      dbg_clear_o <= 1'b0;
      bad_cmd_o   <= 1'b0;
    end else begin
      pending_o   <= accept;
      start_o     <= accept && is_phase;
      dbg_clear_o <= accept && is_clear;
      // nop, zero length and unknown opcodes.
      bad_cmd_o   <= accept && !is_phase && !is_clear;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      start_op_o  <= cmd_op_i;
      start_len_o <= cmd_len_i;
      start_arg_o <= cmd_arg_i;
    end
  end

  a_start_xor_bad: assert property (@(posedge clk) disable iff (!rst_n)
    !(start_o && bad_cmd_o));

endmodule

`default_nettype wire

// File: hw/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ----------------------------------------
  // command opcodes
  // ----------------------------------------
  typedef enum logic [2:0] {
    NOP         = 3'd0,
    SPMM        = 3'd1,
    DMVM        = 3'd2,
    SM          = 3'd3,
    AGGR        = 3'd4,
    CLEAR_DEBUG = 3'd5
  } gat_op_e;

  // engine sequencing.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } eng_state_e;

  // bit positions in the 4-bit phase strobes.
  localparam int unsigned PH_SPMM = 0;
  localparam int unsigned PH_DMVM = 1;
  localparam int unsigned PH_SM   = 2;
  localparam int unsigned PH_AGGR = 3;

endpackage

`default_nettype wire

// File: hw/gat_params.svh
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// operand pulled per beat.
`define GAT_OPND_W 16
// result and debug words.
`define GAT_RES_W 32
// beat count, 1 to 15 beats.
`define GAT_LEN_W 4
// per-command argument.
`define GAT_ARG_W 4

// spmm beat index whose operand the monitor captures.
`define GAT_DBG_WATCH_BEAT 2

`endif
